// ==== exec_alu.sv ====
// Execute ALU and branch comparator
module exec_alu import rv_exec_pkg::*; (
	input  logic [xlen-1:0] rs1,
	input  logic [xlen-1:0] rs2,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] imm,
	input  ex_ctrl_t        ctrl,
	output logic [xlen-1:0] alu_out,
	output logic            br_lt,
	output logic            br_eq
);

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [4:0]      shamt;

	assign op_a  = ctrl.a_sel_pc ? pc : rs1;
	assign op_b  = ctrl.b_sel_imm ? imm : rs2;
	assign shamt = op_b[4:0];

	always_comb begin
		case (ctrl.alu_op)
			alu_add:    alu_out = op_a + op_b;
			alu_sub:    alu_out = op_a - op_b;
			alu_sll:    alu_out = op_a << shamt;
			alu_slt:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
			alu_sltu:   alu_out = {31'd0, op_a < op_b};
			alu_xor:    alu_out = op_a ^ op_b;
			alu_srl:    alu_out = op_a >> shamt;
			alu_sra:    alu_out = $unsigned($signed(op_a) >>> shamt);
			alu_or:     alu_out = op_a | op_b;
			alu_and:    alu_out = op_a & op_b;
			alu_pass_b: alu_out = op_b;
			default:    alu_out = op_a + op_b;
		endcase
	end

	// comparator always looks at the register operands
	always_comb begin
		br_eq = (rs1 == rs2);
		if (ctrl.br_unsigned) begin
			br_lt = (rs1 < rs2);
		end else begin
			br_lt = ($signed(rs1) < $signed(rs2));
		end
	end

endmodule

// ==== exec_ctrl_dec.sv ====
// Execute control decoder
module exec_ctrl_dec import rv_exec_pkg::*; (
	input  rv_inst_t inst,
	output ex_ctrl_t ctrl
);

	// shared funct3 decode for reg-reg and reg-imm ops
	// sub only exists in the reg-reg form
	function automatic alu_op_t arith_op(
		input logic [2:0] funct3,
		input logic       alt,
		input logic       sub_ok
	);
		case (funct3)
			3'b000:  arith_op = (alt && sub_ok) ? alu_sub : alu_add;
			3'b001:  arith_op = alu_sll;
			3'b010:  arith_op = alu_slt;
			3'b011:  arith_op = alu_sltu;
			3'b100:  arith_op = alu_xor;
			3'b101:  arith_op = alt ? alu_sra : alu_srl;
			3'b110:  arith_op = alu_or;
			default: arith_op = alu_and;
		endcase
	endfunction

	always_comb begin
		// address-style add on rs1 and imm unless told otherwise
		ctrl.alu_op      = alu_add;
		ctrl.a_sel_pc    = 1'b0;
		ctrl.b_sel_imm   = 1'b1;
		ctrl.br_unsigned = 1'b0;
		ctrl.store_size  = st_none;

		case (inst.r.opcode)
			op_reg: begin
				ctrl.b_sel_imm = 1'b0;
				ctrl.alu_op    = arith_op(inst.r.funct3, inst.r.funct7[5], 1'b1);
			end
			op_imm: begin
				// imm bit 10 is inst[30] and only matters for srai
				ctrl.alu_op = arith_op(inst.i.funct3, inst.i.imm12[10], 1'b0);
			end
			op_lui: begin
				ctrl.alu_op = alu_pass_b;
			end
			op_auipc, op_jal: begin
				ctrl.a_sel_pc = 1'b1;
			end
			op_branch: begin
				// alu computes the target while the comparator runs on rs1/rs2
				ctrl.a_sel_pc    = 1'b1;
				ctrl.br_unsigned = inst.b.funct3[2] & inst.b.funct3[1];
			end
			op_store: begin
				case (inst.s.funct3)
					3'b000:  ctrl.store_size = st_byte;
					3'b001:  ctrl.store_size = st_half;
					3'b010:  ctrl.store_size = st_word;
					default: ctrl.store_size = st_none;
				endcase
			end
			default: begin
				// jalr, load and unknown opcodes keep the address add
			end
		endcase
	end

endmodule

// ==== exec_fwd_unit.sv ====
// Write-back forwarding unit
module exec_fwd_unit import rv_exec_pkg::*; (
	input  ex_in_t          cur,
	input  rv_inst_t        prev_inst,
	input  logic            prev_valid,
	input  logic [xlen-1:0] wb_data,
	output logic [xlen-1:0] rs1_fwd,
	output logic [xlen-1:0] rs2_fwd
);

	logic prev_writes;
	logic fwd_rs1;
	logic fwd_rs2;

	// stage-3 instruction will write a real register
	assign prev_writes = prev_valid
		&& (prev_inst.r.opcode != op_branch)
		&& (prev_inst.r.opcode != op_store)
		&& (prev_inst.r.rd != 5'd0);

	assign fwd_rs1 = cur.valid && prev_writes && (prev_inst.r.rd == cur.inst.r.rs1);
	assign fwd_rs2 = cur.valid && prev_writes && (prev_inst.r.rd == cur.inst.r.rs2);

	// operand muxes
	assign rs1_fwd = fwd_rs1 ? wb_data : cur.rs1_data;
	assign rs2_fwd = fwd_rs2 ? wb_data : cur.rs2_data;

endmodule

// ==== exec_stage.sv ====
// RV32I execute stage top
module exec_stage import rv_exec_pkg::*; (
	input  logic            clk,
	input  logic            reset,
	input  ex_in_t          ex_in,
	input  logic [xlen-1:0] wb_data,
	output ex_out_t         ex_out
);

	logic [xlen-1:0] rs1_fwd;
	logic [xlen-1:0] rs2_fwd;
	logic [xlen-1:0] alu_out;
	logic [xlen-1:0] store_data;
	logic [3:0]      byte_mask;
	logic            br_lt;
	logic            br_eq;
	ex_ctrl_t        ex_ctrl;
	ex_out_t         ex_next;

	exec_ctrl_dec u_ctrl_dec (
		.inst (ex_in.inst),
		.ctrl (ex_ctrl)
	);

	// stage-3 register doubles as the forwarding source
	exec_fwd_unit u_fwd_unit (
		.cur        (ex_in),
		.prev_inst  (ex_out.inst),
		.prev_valid (ex_out.valid),
		.wb_data    (wb_data),
		.rs1_fwd    (rs1_fwd),
		.rs2_fwd    (rs2_fwd)
	);

	exec_alu u_alu (
		.rs1     (rs1_fwd),
		.rs2     (rs2_fwd),
		.pc      (ex_in.pc),
		.imm     (ex_in.imm),
		.ctrl    (ex_ctrl),
		.alu_out (alu_out),
		.br_lt   (br_lt),
		.br_eq   (br_eq)
	);

	// store address low bits come straight from the alu sum
	store_align u_store_align (
		.rs2        (rs2_fwd),
		.size       (ex_ctrl.store_size),
		.addr_lo    (alu_out[1:0]),
		.store_data (store_data),
		.byte_mask  (byte_mask)
	);

	always_comb begin
		ex_next.valid      = ex_in.valid;
		ex_next.pc         = ex_in.pc;
		ex_next.inst       = ex_in.inst;
		ex_next.alu_out    = alu_out;
		ex_next.store_data = store_data;
		ex_next.byte_mask  = byte_mask;
		ex_next.br_lt      = br_lt;
		ex_next.br_eq      = br_eq;
	end

	// stage-3 register
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_out <= '0;
		end else begin
			ex_out <= ex_next;
		end
	end

endmodule

// ==== project.f ====
+incdir+.
rv_exec_pkg.sv
exec_ctrl_dec.sv
exec_fwd_unit.sv
exec_alu.sv
store_align.sv
exec_stage.sv
tb_exec_stage.sv

// ==== rv_exec_pkg.sv ====
// RV32I execute stage definitions
package rv_exec_pkg;

	localparam int xlen = 32;

	// base opcodes used by the execute stage
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;

	// encoded as {inst[30], funct3} where that makes sense
	typedef enum logic [3:0] {
		alu_add    = 4'b0000,
		alu_sll    = 4'b0001,
		alu_slt    = 4'b0010,
		alu_sltu   = 4'b0011,
		alu_xor    = 4'b0100,
		alu_srl    = 4'b0101,
		alu_or     = 4'b0110,
		alu_and    = 4'b0111,
		alu_sub    = 4'b1000,
		alu_sra    = 4'b1101,
		alu_pass_b = 4'b1111
	} alu_op_t;

	// low bits line up with store funct3
	typedef enum logic [1:0] {
		st_byte = 2'b00,
		st_half = 2'b01,
		st_word = 2'b10,
		st_none = 2'b11
	} store_size_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// immediate bits are scrambled, field positions match s_fmt
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
	} rv_inst_t;

	// stage-2 input bundle
	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		rv_inst_t        inst;
		logic [xlen-1:0] imm;
		logic [xlen-1:0] rs1_data;
		logic [xlen-1:0] rs2_data;
	} ex_in_t;

	typedef struct packed {
		alu_op_t     alu_op;
		logic        a_sel_pc;
		logic        b_sel_imm;
		logic        br_unsigned;
		store_size_t store_size;
	} ex_ctrl_t;

	// stage-3 bundle
	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		rv_inst_t        inst;
		logic [xlen-1:0] alu_out;
		logic [xlen-1:0] store_data;
		logic [3:0]      byte_mask;
		logic            br_lt;
		logic            br_eq;
	} ex_out_t;

endpackage

// ==== store_align.sv ====
// Store data lane alignment
module store_align import rv_exec_pkg::*; (
	input  logic [xlen-1:0] rs2,
	input  store_size_t     size,
	input  logic [1:0]      addr_lo,
	output logic [xlen-1:0] store_data,
	output logic [3:0]      byte_mask
);

	always_comb begin
		case (size)
			st_byte: begin
				// copy into every lane, mask picks the one that counts
				store_data = {4{rs2[7:0]}};
				byte_mask  = 4'b0001 << addr_lo;
			end
			st_half: begin
				store_data = {2{rs2[15:0]}};
				byte_mask  = addr_lo[1] ? 4'b1100 : 4'b0011;
			end
			st_word: begin
				store_data = rs2;
				byte_mask  = 4'b1111;
			end
			default: begin
				// not a store
				store_data = rs2;
				byte_mask  = 4'b0000;
			end
		endcase
	end

endmodule

// ==== tb_exec_model.svh ====
// Execute stage reference model
`ifndef TB_EXEC_MODEL_SVH
`define TB_EXEC_MODEL_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function automatic logic [31:0] next_rand();
	rng_state = xorshift32(rng_state);
	return rng_state;
endfunction

function automatic logic [6:0] pick_opcode(input logic [15:0] r);
	case (r % 9)
		0: return op_lui;
		1: return op_auipc;
		2: return op_jal;
		3: return op_jalr;
		4: return op_branch;
		5: return op_load;
		6: return op_store;
		7: return op_imm;
		default: return op_reg;
	endcase
endfunction

// registers limited to x0..x3 so forwarding hits often
function automatic ex_in_t random_ex_in();
	ex_in_t s;
	logic [31:0] r;
	s = '0;
	r = next_rand();
	s.valid = (r % 10) != 0;
	r = next_rand();
	s.inst = {1'b0, r[0], 5'd0, 3'd0, r[2:1], 3'd0, r[4:3], r[7:5], 3'd0, r[9:8],
		pick_opcode(r[31:16])};
	s.pc = next_rand();
	s.imm = next_rand();
	s.rs1_data = next_rand();
	s.rs2_data = next_rand();
	// equal operands now and then for br_eq
	if (r[12:10] == 3'd0) begin
		s.rs2_data = s.rs1_data;
	end
	return s;
endfunction

// expected stage-3 bundle for cur, with prev sitting in stage 3
function automatic ex_out_t predict_out(input ex_in_t cur, input ex_in_t prev,
	input logic [31:0] wb);
	ex_out_t e;
	logic [6:0] opc;
	logic [2:0] f3;
	logic prev_wr;
	logic [31:0] v1;
	logic [31:0] v2;
	logic [31:0] a;
	logic [31:0] b;
	logic signed [31:0] sa;
	opc = cur.inst[6:0];
	f3 = cur.inst[14:12];
	prev_wr = prev.valid && (prev.inst[11:7] != 5'd0)
		&& (prev.inst[6:0] != op_branch) && (prev.inst[6:0] != op_store);
	v1 = (cur.valid && prev_wr && prev.inst[11:7] == cur.inst[19:15]) ? wb : cur.rs1_data;
	v2 = (cur.valid && prev_wr && prev.inst[11:7] == cur.inst[24:20]) ? wb : cur.rs2_data;
	a = (opc == op_auipc || opc == op_jal || opc == op_branch) ? cur.pc : v1;
	b = (opc == op_reg) ? v2 : cur.imm;
	sa = a;
	e = '0;
	e.valid = cur.valid;
	e.pc = cur.pc;
	e.inst = cur.inst;
	e.alu_out = a + b;
	if (opc == op_lui) begin
		e.alu_out = b;
	end else if (opc == op_reg || opc == op_imm) begin
		case (f3)
			3'b000: e.alu_out = (opc == op_reg && cur.inst[30]) ? a - b : a + b;
			3'b001: e.alu_out = a << b[4:0];
			3'b010: e.alu_out = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
			3'b011: e.alu_out = {31'd0, a < b};
			3'b100: e.alu_out = a ^ b;
			3'b101: begin
				if (cur.inst[30]) begin
					e.alu_out = sa >>> b[4:0];
				end else begin
					e.alu_out = a >> b[4:0];
				end
			end
			3'b110: e.alu_out = a | b;
			default: e.alu_out = a & b;
		endcase
	end
	e.br_eq = (v1 == v2);
	if (opc == op_branch && f3[2:1] == 2'b11) begin
		e.br_lt = v1 < v2;
	end else begin
		e.br_lt = (v1[31] != v2[31]) ? v1[31] : (v1 < v2);
	end
	// store lanes follow the address low bits
	e.store_data = v2;
	if (opc == op_store && f3 == 3'b000) begin
		e.store_data = {4{v2[7:0]}};
		e.byte_mask = 4'b0001 << e.alu_out[1:0];
	end else if (opc == op_store && f3 == 3'b001) begin
		e.store_data = {2{v2[15:0]}};
		e.byte_mask = e.alu_out[1] ? 4'b1100 : 4'b0011;
	end else if (opc == op_store && f3 == 3'b010) begin
		e.byte_mask = 4'b1111;
	end
	return e;
endfunction

`endif

// ==== tb_exec_stage.sv ====
// Execute stage testbench
module tb_exec_stage import rv_exec_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_insts = 2000;
	localparam int idle_timeout = 8;

	logic            clk;
	logic            reset;
	ex_in_t          ex_in;
	logic [xlen-1:0] wb_data;
	ex_out_t         ex_out;

	logic [31:0] rng_state;
	int          value_errors;
	int          timeout_errors;

	`include "tb_exec_model.svh"

	exec_stage dut0 (
		.clk     (clk),
		.reset   (reset),
		.ex_in   (ex_in),
		.wb_data (wb_data),
		.ex_out  (ex_out)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	task automatic check_out(input ex_out_t exp);
		assert (ex_out.valid === exp.valid) else begin
			value_errors++;
			$display("ERR %0t: valid %b, expected %b", $time, ex_out.valid, exp.valid);
		end
		assert (ex_out.pc === exp.pc && ex_out.inst === exp.inst) else begin
			value_errors++;
			$display("ERR %0t: pc/inst %h/%h, expected %h/%h", $time,
				ex_out.pc, ex_out.inst, exp.pc, exp.inst);
		end
		assert (ex_out.alu_out === exp.alu_out) else begin
			value_errors++;
			$display("ERR %0t: alu_out %h, expected %h (inst %h)", $time,
				ex_out.alu_out, exp.alu_out, exp.inst);
		end
		assert (ex_out.store_data === exp.store_data && ex_out.byte_mask === exp.byte_mask)
		else begin
			value_errors++;
			$display("ERR %0t: store %h/%b, expected %h/%b", $time,
				ex_out.store_data, ex_out.byte_mask, exp.store_data, exp.byte_mask);
		end
		assert (ex_out.br_lt === exp.br_lt && ex_out.br_eq === exp.br_eq) else begin
			value_errors++;
			$display("ERR %0t: br_lt/br_eq %b/%b, expected %b/%b", $time,
				ex_out.br_lt, ex_out.br_eq, exp.br_lt, exp.br_eq);
		end
	endtask

	task automatic wait_out_idle(input int max_cycles);
		int n;
		n = 0;
		while (ex_out.valid !== 1'b0 && n < max_cycles) begin
			@(negedge clk);
			n++;
		end
		if (ex_out.valid !== 1'b0) begin
			timeout_errors++;
			$display("timeout: ex_out.valid still high after %0d cycles", max_cycles);
		end
	endtask

	initial begin
		ex_in_t  cur_in;
		ex_in_t  prev_in;
		ex_out_t exp;
		rng_state = 32'hdce9af72;
		value_errors = 0;
		timeout_errors = 0;
		reset = 1'b1;
		// valid garbage that only reset keeps out of ex_out
		ex_in = random_ex_in();
		ex_in.valid = 1'b1;
		wb_data = '0;
		prev_in = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		wait_out_idle(idle_timeout);
		// nothing accepted since reset
		assert (ex_out === '0) else begin
			value_errors++;
			$display("ERR %0t: ex_out not cleared after reset", $time);
		end
		if (timeout_errors == 0) begin
			for (int i = 0; i < num_insts; i++) begin
				if (i > 0) begin
					check_out(exp);
				end
				cur_in = random_ex_in();
				ex_in = cur_in;
				wb_data = next_rand();
				exp = predict_out(cur_in, prev_in, wb_data);
				prev_in = cur_in;
				@(negedge clk);
			end
			check_out(exp);
			ex_in.valid = 1'b0;
			wait_out_idle(idle_timeout);
		end
		$display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
